// File: build.f
+incdir+verilog
+incdir+test
verilog/stream_pkg.sv
verilog/type_slot.sv
verilog/ndata_to_axi_packer.sv
verilog/axi_to_ndata_unpacker.sv
verilog/typed_stream_bridge.sv
test/tb_typed_stream_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the typed stream bridge testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f build.f \
    --top-module tb_typed_stream_bridge -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile step returned an error"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: test/tb_stream_model.svh
`ifndef TB_STREAM_MODEL_SVH
`define TB_STREAM_MODEL_SVH

logic [31:0] lfsr_state = 32'h0b40_8d8b;
int          error_count = 0;
int          check_count = 0;
axi_beat_t   exp_axi_q[$];
ndata_beat_t exp_lane_q[$];
axi_beat_t   pend_axi;                  // Lower half waiting for its upper half
logic        pend_upper = 1'b0;

// Taps 32, 22, 2, 1, one step per bit returned
function automatic logic [63:0] rand_bits(int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val = {val[62:0], fb};
    end
    return val;
endfunction

task automatic check(string what, logic [319:0] got, logic [319:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

function automatic int elem_bits(elem_type_t typ);
    case (typ)
        INT32, UINT32, FLOAT32: return 32;
        default:                return 64;
    endcase
endfunction

// Expected AXI beats for one accepted lane beat
task automatic model_tx_beat(elem_type_t typ, ndata_beat_t beat);
    axi_beat_t b;
    int        dbase;
    int        kbase;
    if (elem_bits(typ) == 64) begin
        b.tdata = beat.data;
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            for (int j = 0; j < 8; j++) b.tkeep[i*8 + j] = beat.keep[i];
        end
        b.tlast = beat.last;
        exp_axi_q.push_back(b);
    end else begin
        b     = pend_upper ? pend_axi : '0;
        dbase = pend_upper ? `AXI_WIDTH / 2 : 0;
        kbase = pend_upper ? `KEEP_WIDTH / 2 : 0;
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            b.tdata[dbase + 32*i +: 32] = beat.data[i][31:0];
            for (int j = 0; j < 4; j++) b.tkeep[kbase + 4*i + j] = beat.keep[i];
        end
        b.tlast = beat.last;
        if (pend_upper || beat.last) begin
            exp_axi_q.push_back(b);
            pend_upper = 1'b0;
        end else begin
            pend_axi   = b;
            pend_upper = 1'b1;
        end
    end
endtask

// Expected lane beats for one offered AXI beat
task automatic model_rx_beat(elem_type_t typ, axi_beat_t a);
    ndata_beat_t l;
    if (elem_bits(typ) == 64) begin
        l.data = a.tdata;
        for (int i = 0; i < `NUM_ELEMENTS; i++) l.keep[i] = a.tkeep[8*i];
        l.last = a.tlast;
        exp_lane_q.push_back(l);
    end else begin
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < `NUM_ELEMENTS; i++) begin
                l.data[i] = {32'h0, a.tdata[h*(`AXI_WIDTH/2) + 32*i +: 32]};
                l.keep[i] = a.tkeep[h*(`KEEP_WIDTH/2) + 4*i];
            end
            l.last = a.tlast && (h == 1);
            exp_lane_q.push_back(l);
        end
    end
endtask

`endif

// File: test/tb_typed_stream_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module tb_typed_stream_bridge
    import stream_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int TOTAL_PKTS   = 32;       // Sum over all packet tests

    logic        clk;
    logic        rst_n;
    elem_type_t  tx_type;
    logic        tx_type_valid;
    logic        tx_type_ready;
    ndata_beat_t tx_in;
    logic        tx_in_valid;
    logic        tx_in_ready;
    axi_beat_t   tx_axi;
    logic        tx_axi_tvalid;
    logic        tx_axi_tready;
    elem_type_t  rx_type;
    logic        rx_type_valid;
    logic        rx_type_ready;
    axi_beat_t   rx_axi;
    logic        rx_axi_tvalid;
    logic        rx_axi_tready;
    ndata_beat_t rx_out;
    logic        rx_out_valid;
    logic        rx_out_ready;

    elem_type_t  tx_pkt_type[$];
    elem_type_t  rx_pkt_type[$];
    int          tx_pkt_len[$];
    int          rx_pkt_len[$];
    logic        gaps_on;
    int          cycle_count = 0;
    int          cycle_limit = RESET_CYCLES + 20 + 40 * TOTAL_PKTS;
    int          test_count = 0;
    int          tx_ahead_count = 0;    // Types taken while AXI beats are still owed
    axi_beat_t   exp_axi_head;
    ndata_beat_t exp_lane_head;

    `include "tb_stream_model.svh"

    typed_stream_bridge u_typed_stream_bridge (
        .clk             (clk),
        .rst_n           (rst_n),
        .tx_type_i       (tx_type),
        .tx_type_valid_i (tx_type_valid),
        .tx_type_ready_o (tx_type_ready),
        .tx_in_i         (tx_in),
        .tx_in_valid_i   (tx_in_valid),
        .tx_in_ready_o   (tx_in_ready),
        .tx_axi_o        (tx_axi),
        .tx_axi_tvalid_o (tx_axi_tvalid),
        .tx_axi_tready_i (tx_axi_tready),
        .rx_type_i       (rx_type),
        .rx_type_valid_i (rx_type_valid),
        .rx_type_ready_o (rx_type_ready),
        .rx_axi_i        (rx_axi),
        .rx_axi_tvalid_i (rx_axi_tvalid),
        .rx_axi_tready_o (rx_axi_tready),
        .rx_out_o        (rx_out),
        .rx_out_valid_o  (rx_out_valid),
        .rx_out_ready_i  (rx_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no progress within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // Output back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        if (gaps_on) begin
            tx_axi_tready <= rand_bits(2) != '0;
            rx_out_ready  <= rand_bits(2) != '0;
        end else begin
            tx_axi_tready <= 1'b1;
            rx_out_ready  <= 1'b1;
        end
    end

    // Sampled mid-cycle, the transfer happens on the next rising edge
    always @(negedge clk) begin
        if (rst_n && tx_type_valid && tx_type_ready && exp_axi_q.size() != 0) begin
            tx_ahead_count++;                   // Previous packet not yet out
        end
        if (rst_n && tx_axi_tvalid && tx_axi_tready) begin
            if (exp_axi_q.size() == 0) begin
                error_count++;
                $display("Transmit side sent an AXI beat that was not expected at %0t", $time);
            end else begin
                exp_axi_head = exp_axi_q.pop_front();
                check("transmit AXI beat", {31'b0, tx_axi}, {31'b0, exp_axi_head});
            end
        end
        if (rst_n && rx_out_valid && rx_out_ready) begin
            if (exp_lane_q.size() == 0) begin
                error_count++;
                $display("Receive side sent a lane beat that was not expected at %0t", $time);
            end else begin
                exp_lane_head = exp_lane_q.pop_front();
                check("receive lane beat", {59'b0, rx_out}, {59'b0, exp_lane_head});
            end
        end
    end

    // Mode 0 picks 64-bit codes, mode 1 picks 32-bit codes, else any
    function automatic elem_type_t pick_type(int mode);
        logic [63:0] r;
        int          code;
        r    = rand_bits(3);
        code = int'(r % 3);
        if (mode == 0) code = code + 3;
        else if (mode != 1) code = int'(r % 6);
        return elem_type_t'(code[3:0]);
    endfunction

    task automatic make_packets(int mode, int npkts);
        logic [63:0] r;
        tx_pkt_type.delete();
        rx_pkt_type.delete();
        tx_pkt_len.delete();
        rx_pkt_len.delete();
        for (int k = 0; k < npkts; k++) begin
            tx_pkt_type.push_back(pick_type(mode));
            rx_pkt_type.push_back(pick_type(mode));
            r = rand_bits(3);
            tx_pkt_len.push_back(int'(r % 6) + 1);
            r = rand_bits(3);
            rx_pkt_len.push_back(int'(r % 6) + 1);
        end
    endtask

    // Types run ahead of their packets, the slot decides when they land
    task automatic drive_tx_types();
        for (int p = 0; p < tx_pkt_type.size(); p++) begin
            tx_type       <= tx_pkt_type[p];
            tx_type_valid <= 1'b1;
            do @(negedge clk); while (!(tx_type_valid && tx_type_ready));
            @(posedge clk);
        end
        tx_type_valid <= 1'b0;
    endtask

    task automatic drive_rx_types();
        for (int p = 0; p < rx_pkt_type.size(); p++) begin
            rx_type       <= rx_pkt_type[p];
            rx_type_valid <= 1'b1;
            do @(negedge clk); while (!(rx_type_valid && rx_type_ready));
            @(posedge clk);
        end
        rx_type_valid <= 1'b0;
    endtask

    task automatic drive_tx_beats();
        ndata_beat_t beat;
        logic [63:0] r;
        for (int p = 0; p < tx_pkt_type.size(); p++) begin
            for (int b = 0; b < tx_pkt_len[p]; b++) begin
                for (int i = 0; i < `NUM_ELEMENTS; i++) beat.data[i] = rand_bits(64);
                r         = rand_bits(`NUM_ELEMENTS);
                beat.keep = r[`NUM_ELEMENTS-1:0];
                beat.last = (b == tx_pkt_len[p] - 1);
                tx_in       <= beat;
                tx_in_valid <= 1'b1;
                do @(negedge clk); while (!(tx_in_valid && tx_in_ready));
                @(posedge clk);
                model_tx_beat(tx_pkt_type[p], beat);
            end
        end
        tx_in_valid <= 1'b0;
    endtask

    task automatic drive_rx_beats();
        axi_beat_t   a;
        logic [63:0] r;
        for (int p = 0; p < rx_pkt_type.size(); p++) begin
            for (int b = 0; b < rx_pkt_len[p]; b++) begin
                for (int w = 0; w < `NUM_ELEMENTS; w++) a.tdata[w*64 +: 64] = rand_bits(64);
                r       = rand_bits(`KEEP_WIDTH);
                a.tkeep = r[`KEEP_WIDTH-1:0];
                a.tlast = (b == rx_pkt_len[p] - 1);
                model_rx_beat(rx_pkt_type[p], a);
                rx_axi        <= a;
                rx_axi_tvalid <= 1'b1;
                do @(negedge clk); while (!(rx_axi_tvalid && rx_axi_tready));
                @(posedge clk);
            end
        end
        rx_axi_tvalid <= 1'b0;
    endtask

    task automatic report_test(string name, int errs_before);
        test_count++;
        $display("%-34s %s (%0d errors)", name,
                 (error_count == errs_before) ? "PASS" : "FAIL", error_count - errs_before);
    endtask

    task automatic run_test(string name, int mode, int npkts, logic gaps);
        int errs;
        errs = error_count;
        @(posedge clk);
        make_packets(mode, npkts);
        tx_ahead_count = 0;
        gaps_on <= gaps;
        fork
            drive_tx_types();
            drive_tx_beats();
            drive_rx_types();
            drive_rx_beats();
        join
        while (exp_axi_q.size() != 0 || exp_lane_q.size() != 0) @(posedge clk);
        gaps_on <= 1'b0;
        repeat (2) @(posedge clk);
        check("tx type taken with packet in flight", {319'b0, tx_ahead_count != 0}, 320'd1);
        report_test(name, errs);
    endtask

    initial begin
        int errs;
        rst_n         <= 1'b0;
        tx_type       <= INT32;
        tx_type_valid <= 1'b0;
        tx_in         <= '0;
        tx_in_valid   <= 1'b0;
        tx_axi_tready <= 1'b1;
        rx_type       <= INT32;
        rx_type_valid <= 1'b0;
        rx_axi        <= '0;
        rx_axi_tvalid <= 1'b0;
        rx_out_ready  <= 1'b1;
        gaps_on       <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);

        errs = error_count;
        check("tx tvalid after reset", {319'b0, tx_axi_tvalid}, '0);
        check("rx out valid after reset", {319'b0, rx_out_valid}, '0);
        check("tx type ready after reset", {319'b0, tx_type_ready}, 320'd1);
        check("rx type ready after reset", {319'b0, rx_type_ready}, 320'd1);
        report_test("reset state", errs);

        run_test("64-bit types both directions", 0, 6, 1'b0);
        run_test("32-bit types both directions", 1, 6, 1'b0);
        run_test("mixed widths", 2, 8, 1'b0);
        run_test("mixed widths with back-pressure", 2, 12, 1'b1);

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/axi_to_ndata_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module axi_to_ndata_unpacker
    import stream_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,

    input  wire elem_type_t elem_type_i,
    input  wire logic       type_valid_i,
    output logic            release_o,

    input  wire axi_beat_t  axi_i,
    input  wire logic       axi_tvalid_i,
    output logic            axi_tready_o,

    output ndata_beat_t     out_o,
    output logic            out_valid_o,
    input  wire logic       out_ready_i
);

    logic       is_32bit;
    logic       upper;          // Half currently presented in 32-bit mode
    logic       beat_ready;
    logic       out_xfer;

    half_data_t half_data;
    half_keep_t half_keep;
    word_t      word;

    elem_t [`NUM_ELEMENTS-1:0] lanes_32;
    lane_keep_t                keep_32;
    lane_keep_t                keep_64;

    assign is_32bit = type_width(elem_type_i) == 32;

    // AXI beat is consumed with its second lane beat
    assign beat_ready   = is_32bit ? out_ready_i && upper : out_ready_i;
    assign axi_tready_o = type_valid_i && beat_ready;

    assign out_valid_o = type_valid_i && axi_tvalid_i;
    assign out_xfer    = out_valid_o && out_ready_i;
    assign release_o   = out_xfer && out_o.last;

    assign half_data = upper ? axi_i.tdata[`AXI_WIDTH-1 -: `HALF_WIDTH]
                             : axi_i.tdata[`HALF_WIDTH-1:0];
    assign half_keep = upper ? axi_i.tkeep[`KEEP_WIDTH-1 -: `HALF_KEEP]
                             : axi_i.tkeep[`HALF_KEEP-1:0];

    always_comb begin
        word = '0;
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            word        = half_data[i*`WORD_WIDTH +: `WORD_WIDTH];
            lanes_32[i] = {{(`ELEM_WIDTH - `WORD_WIDTH){1'b0}}, word}; // Zero-extend
            keep_32[i]  = half_keep[i*`WORD_BYTES];
            keep_64[i]  = axi_i.tkeep[i*`ELEM_BYTES];
        end
    end

    always_comb begin
        if (is_32bit) begin
            out_o.data = lanes_32;
            out_o.keep = keep_32;
            out_o.last = axi_i.tlast && upper;         // Only after the upper half
        end else begin
            out_o.data = axi_i.tdata;
            out_o.keep = keep_64;
            out_o.last = axi_i.tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upper <= 1'b0;
        end else if (out_xfer && is_32bit) begin
            upper <= !upper;
        end
    end

    a_type_supported: assert property (
        @(posedge clk) disable iff (!rst_n)
        type_valid_i |-> type_width(elem_type_i) inside {32, 64}
    ) else $error("unpacker: unsupported element type %0d", elem_type_i);

endmodule

`default_nettype wire

// File: verilog/ndata_to_axi_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module ndata_to_axi_packer
    import stream_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,

    input  wire elem_type_t  elem_type_i,
    input  wire logic        type_valid_i,
    output logic             release_o,

    input  wire ndata_beat_t in_i,
    input  wire logic        in_valid_i,
    output logic             in_ready_o,

    output axi_beat_t        axi_o,
    output logic             axi_tvalid_o,
    input  wire logic        axi_tready_i
);

    logic       is_32bit;
    logic       upper;          // Next 32-bit beat goes to the upper half
    logic       in_xfer;
    logic       beat_done;      // This transfer completes an AXI beat

    half_data_t data_32;
    half_keep_t keep_32;
    axi_keep_t  keep_64;

    axi_beat_t  out_beat;
    axi_beat_t  next_beat;
    logic       out_valid;

    assign is_32bit   = type_width(elem_type_i) == 32;
    assign in_ready_o = type_valid_i && axi_tready_i;
    assign in_xfer    = in_valid_i && in_ready_o;
    assign release_o  = in_xfer && in_i.last;
    assign beat_done  = in_xfer && (!is_32bit || upper || in_i.last);

    // Lane keep bits spread to byte strobes
    always_comb begin
        for (int i = 0; i < `NUM_ELEMENTS; i++) begin
            data_32[i*`WORD_WIDTH +: `WORD_WIDTH] = in_i.data[i][`WORD_WIDTH-1:0];
            for (int j = 0; j < `WORD_BYTES; j++) begin
                keep_32[i*`WORD_BYTES + j] = in_i.keep[i];
            end
            for (int j = 0; j < `ELEM_BYTES; j++) begin
                keep_64[i*`ELEM_BYTES + j] = in_i.keep[i];
            end
        end
    end

    always_comb begin
        next_beat       = out_beat;
        next_beat.tlast = in_i.last;
        if (!is_32bit) begin
            next_beat.tdata = in_i.data;
            next_beat.tkeep = keep_64;
        end else if (!upper) begin
            // Lower half starts a fresh beat, upper half stays empty
            next_beat.tdata = {{`HALF_WIDTH{1'b0}}, data_32};
            next_beat.tkeep = {{`HALF_KEEP{1'b0}}, keep_32};
        end else begin
            next_beat.tdata[`AXI_WIDTH-1 -: `HALF_WIDTH] = data_32;
            next_beat.tkeep[`KEEP_WIDTH-1 -: `HALF_KEEP] = keep_32;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upper     <= 1'b0;
            out_valid <= 1'b0;
        end else if (axi_tready_i) begin
            out_valid <= beat_done;                    // Single cycle unless refilled
            if (in_xfer && is_32bit) begin
                upper <= in_i.last ? 1'b0 : !upper;    // Packets start on the lower half
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out_beat <= next_beat;
        end
    end

    assign axi_o        = out_beat;
    assign axi_tvalid_o = out_valid;

    a_type_supported: assert property (
        @(posedge clk) disable iff (!rst_n)
        type_valid_i |-> type_width(elem_type_i) inside {32, 64}
    ) else $error("packer: unsupported element type %0d", elem_type_i);

    a_axi_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        axi_tvalid_o && !axi_tready_i |=> axi_tvalid_o && $stable(axi_o)
    ) else $error("packer: AXI beat changed while stalled");

endmodule

`default_nettype wire

// File: verilog/stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Lane geometry of the element stream
`define NUM_ELEMENTS 4
`define ELEM_WIDTH   64
`define WORD_WIDTH   32

// Bytes per element, one strobe per byte on the AXI side
`define ELEM_BYTES   (`ELEM_WIDTH / 8)
`define WORD_BYTES   (`WORD_WIDTH / 8)

// Derived AXI stream widths
`define AXI_WIDTH    (`NUM_ELEMENTS * `ELEM_WIDTH)
`define KEEP_WIDTH   (`AXI_WIDTH / 8)
`define HALF_WIDTH   (`AXI_WIDTH / 2)
`define HALF_KEEP    (`KEEP_WIDTH / 2)

`endif

// File: verilog/stream_pkg.sv
`default_nettype none

`include "stream_consts.svh"

package stream_pkg;

    // Element type codes, anything else is unsupported
    typedef enum logic [3:0] {
        INT32   = 4'd0,
        UINT32  = 4'd1,
        FLOAT32 = 4'd2,
        INT64   = 4'd3,
        UINT64  = 4'd4,
        DOUBLE  = 4'd5
    } elem_type_t;

    typedef logic [`ELEM_WIDTH-1:0]   elem_t;      // One lane
    typedef logic [`WORD_WIDTH-1:0]   word_t;      // Low part of a lane
    typedef logic [`NUM_ELEMENTS-1:0] lane_keep_t; // One bit per lane
    typedef logic [`AXI_WIDTH-1:0]    axi_data_t;
    typedef logic [`KEEP_WIDTH-1:0]   axi_keep_t;
    typedef logic [`HALF_WIDTH-1:0]   half_data_t; // Packed 32-bit elements
    typedef logic [`HALF_KEEP-1:0]    half_keep_t;

    // Lane side beat, lane 0 in the low bits
    typedef struct packed {
        elem_t [`NUM_ELEMENTS-1:0] data;
        lane_keep_t                keep;
        logic                      last;
    } ndata_beat_t;

    typedef struct packed {
        axi_data_t tdata;
        axi_keep_t tkeep;
        logic      tlast;
    } axi_beat_t;

    // Element width in bits, 0 when the code is unsupported
    function automatic int unsigned type_width(elem_type_t typ);
        int unsigned width;
        case (typ)
            INT32, UINT32, FLOAT32: width = 32;
            INT64, UINT64, DOUBLE:  width = 64;
            default:                width = 0;
        endcase
        return width;
    endfunction

endpackage

`default_nettype wire

// File: verilog/type_slot.sv
`timescale 1ns/1ps
`default_nettype none

module type_slot
    import stream_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,

    input  wire elem_type_t type_i,
    input  wire logic       type_valid_i,
    output logic            type_ready_o,

    input  wire logic       release_i,     // Last beat of the packet moved

    output elem_type_t      cur_type_o,
    output logic            cur_valid_o
);

    elem_type_t held_type;
    logic       held_valid;
    logic       type_xfer;

    assign type_ready_o = !held_valid;                 // Only one type in flight
    assign type_xfer    = type_valid_i && type_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (release_i) begin
            held_valid <= 1'b0;                        // Also covers a single-beat packet
        end else if (type_xfer) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (type_xfer) begin
            held_type <= type_i;
        end
    end

    // Flow-through while empty
    assign cur_type_o  = held_valid ? held_type : type_i;
    assign cur_valid_o = held_valid || type_valid_i;

    // The converter may only end a packet whose type it has seen
    a_release_with_type: assert property (
        @(posedge clk) disable iff (!rst_n)
        release_i |-> cur_valid_o
    ) else $error("type_slot: release without a current type");

endmodule

`default_nettype wire

// File: verilog/typed_stream_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module typed_stream_bridge
    import stream_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,

    // Transmit side
    input  wire elem_type_t  tx_type_i,
    input  wire logic        tx_type_valid_i,
    output logic             tx_type_ready_o,
    input  wire ndata_beat_t tx_in_i,
    input  wire logic        tx_in_valid_i,
    output logic             tx_in_ready_o,
    output axi_beat_t        tx_axi_o,
    output logic             tx_axi_tvalid_o,
    input  wire logic        tx_axi_tready_i,

    // Receive side
    input  wire elem_type_t  rx_type_i,
    input  wire logic        rx_type_valid_i,
    output logic             rx_type_ready_o,
    input  wire axi_beat_t   rx_axi_i,
    input  wire logic        rx_axi_tvalid_i,
    output logic             rx_axi_tready_o,
    output ndata_beat_t      rx_out_o,
    output logic             rx_out_valid_o,
    input  wire logic        rx_out_ready_i
);

    elem_type_t tx_cur_type;
    logic       tx_cur_valid;
    logic       tx_release;

    elem_type_t rx_cur_type;
    logic       rx_cur_valid;
    logic       rx_release;

    type_slot u_tx_slot (
        .clk          (clk),
        .rst_n        (rst_n),
        .type_i       (tx_type_i),
        .type_valid_i (tx_type_valid_i),
        .type_ready_o (tx_type_ready_o),
        .release_i    (tx_release),
        .cur_type_o   (tx_cur_type),
        .cur_valid_o  (tx_cur_valid)
    );

    ndata_to_axi_packer u_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .elem_type_i  (tx_cur_type),
        .type_valid_i (tx_cur_valid),
        .release_o    (tx_release),
        .in_i         (tx_in_i),
        .in_valid_i   (tx_in_valid_i),
        .in_ready_o   (tx_in_ready_o),
        .axi_o        (tx_axi_o),
        .axi_tvalid_o (tx_axi_tvalid_o),
        .axi_tready_i (tx_axi_tready_i)
    );

    type_slot u_rx_slot (
        .clk          (clk),
        .rst_n        (rst_n),
        .type_i       (rx_type_i),
        .type_valid_i (rx_type_valid_i),
        .type_ready_o (rx_type_ready_o),
        .release_i    (rx_release),
        .cur_type_o   (rx_cur_type),
        .cur_valid_o  (rx_cur_valid)
    );

    axi_to_ndata_unpacker u_unpacker (
        .clk          (clk),
        .rst_n        (rst_n),
        .elem_type_i  (rx_cur_type),
        .type_valid_i (rx_cur_valid),
        .release_o    (rx_release),
        .axi_i        (rx_axi_i),
        .axi_tvalid_i (rx_axi_tvalid_i),
        .axi_tready_o (rx_axi_tready_o),
        .out_o        (rx_out_o),
        .out_valid_o  (rx_out_valid_o),
        .out_ready_i  (rx_out_ready_i)
    );

endmodule

`default_nettype wire
